//--- src/mips_isa_pkg.sv
package mips_isa_pkg;

    // one instruction word decoded with either the R layout or the I layout
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;  // funct field selects the operation
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

endpackage

//--- src/mips_core_pkg.sv
package mips_core_pkg;

    localparam int WORD_W     = 32;  // datapath width
    localparam int REG_ADDR_W = 5;   // 32 architectural registers

    localparam int ALU_OP_W = 4;

    // ALU operations
    // for the shifts operand a carries the amount and operand b the value
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd6;   // signed compare
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd7;   // unsigned compare
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd10;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd11;  // low half of operand b to the upper half

endpackage

//--- src/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 instr_valid,
    input  logic [mips_core_pkg::WORD_W-1:0]     instr,
    input  logic [mips_core_pkg::WORD_W-1:0]     instr_pc,
    input  logic [mips_core_pkg::WORD_W-1:0]     rs_data,
    input  logic [mips_core_pkg::WORD_W-1:0]     rt_data,
    output logic [mips_core_pkg::REG_ADDR_W-1:0] rs_addr,
    output logic [mips_core_pkg::REG_ADDR_W-1:0] rt_addr,
    output logic                                 d_valid,
    output logic [mips_core_pkg::WORD_W-1:0]     d_pc,
    output logic [mips_core_pkg::ALU_OP_W-1:0]   d_alu_op,
    output logic [mips_core_pkg::WORD_W-1:0]     d_op_a,
    output logic [mips_core_pkg::WORD_W-1:0]     d_op_b,
    output logic                                 d_fwd_a,
    output logic                                 d_fwd_b,
    output logic [mips_core_pkg::REG_ADDR_W-1:0] d_src_a,
    output logic [mips_core_pkg::REG_ADDR_W-1:0] d_src_b,
    output logic [mips_core_pkg::REG_ADDR_W-1:0] d_dest,
    output logic                                 d_wen,
    output logic                                 d_ri
);

    mips_isa_pkg::instr_t                 ir;
    logic                                 q_valid;
    logic [mips_core_pkg::WORD_W-1:0]     q_pc;
    logic [mips_core_pkg::ALU_OP_W-1:0]   alu_op;
    logic [mips_core_pkg::WORD_W-1:0]     op_a, op_b, imm_sx, imm_zx;
    logic                                 fwd_a, fwd_b, ri;
    logic [mips_core_pkg::REG_ADDR_W-1:0] dest;

    always_ff @(posedge clk) begin
        if (rst) q_valid <= 1'b0;
        else     q_valid <= instr_valid;
    end

    always_ff @(posedge clk) begin
        ir   <= instr;
        q_pc <= instr_pc;
    end

    assign rs_addr = ir.r.rs;  // rs and rt sit in the same bits in both views
    assign rt_addr = ir.r.rt;
    assign imm_sx  = {{(mips_core_pkg::WORD_W-16){ir.i.imm[15]}}, ir.i.imm};
    assign imm_zx  = {{(mips_core_pkg::WORD_W-16){1'b0}}, ir.i.imm};

    always_comb begin
        alu_op = mips_core_pkg::ALU_ADD;
        op_a   = rs_data;
        op_b   = rt_data;
        fwd_a  = 1'b1;
        fwd_b  = 1'b1;
        dest   = ir.r.rd;
        ri     = 1'b0;
        if (ir.r.op == mips_isa_pkg::OP_SPECIAL) begin
            case (ir.r.funct)
                mips_isa_pkg::FN_SLL: begin
                    alu_op = mips_core_pkg::ALU_SLL;
                    op_a   = {{(mips_core_pkg::WORD_W-5){1'b0}}, ir.r.shamt};
                    fwd_a  = 1'b0;
                end
                mips_isa_pkg::FN_SRL: begin
                    alu_op = mips_core_pkg::ALU_SRL;
                    op_a   = {{(mips_core_pkg::WORD_W-5){1'b0}}, ir.r.shamt};
                    fwd_a  = 1'b0;
                end
                mips_isa_pkg::FN_SRA: begin
                    alu_op = mips_core_pkg::ALU_SRA;
                    op_a   = {{(mips_core_pkg::WORD_W-5){1'b0}}, ir.r.shamt};
                    fwd_a  = 1'b0;
                end
                mips_isa_pkg::FN_SLLV: alu_op = mips_core_pkg::ALU_SLL;
                mips_isa_pkg::FN_SRLV: alu_op = mips_core_pkg::ALU_SRL;
                mips_isa_pkg::FN_SRAV: alu_op = mips_core_pkg::ALU_SRA;
                mips_isa_pkg::FN_ADDU: alu_op = mips_core_pkg::ALU_ADD;
                mips_isa_pkg::FN_SUBU: alu_op = mips_core_pkg::ALU_SUB;
                mips_isa_pkg::FN_AND:  alu_op = mips_core_pkg::ALU_AND;
                mips_isa_pkg::FN_OR:   alu_op = mips_core_pkg::ALU_OR;
                mips_isa_pkg::FN_XOR:  alu_op = mips_core_pkg::ALU_XOR;
                mips_isa_pkg::FN_NOR:  alu_op = mips_core_pkg::ALU_NOR;
                mips_isa_pkg::FN_SLT:  alu_op = mips_core_pkg::ALU_SLT;
                mips_isa_pkg::FN_SLTU: alu_op = mips_core_pkg::ALU_SLTU;
                default:               ri     = 1'b1;
            endcase
        end else begin
            dest  = ir.i.rt;
            op_b  = imm_sx;  // sign extension unless the op says otherwise
            fwd_b = 1'b0;
            case (ir.i.op)
                mips_isa_pkg::OP_ADDIU: alu_op = mips_core_pkg::ALU_ADD;
                mips_isa_pkg::OP_SLTI:  alu_op = mips_core_pkg::ALU_SLT;
                mips_isa_pkg::OP_SLTIU: alu_op = mips_core_pkg::ALU_SLTU;
                mips_isa_pkg::OP_ANDI: begin
                    alu_op = mips_core_pkg::ALU_AND;
                    op_b   = imm_zx;
                end
                mips_isa_pkg::OP_ORI: begin
                    alu_op = mips_core_pkg::ALU_OR;
                    op_b   = imm_zx;
                end
                mips_isa_pkg::OP_XORI: begin
                    alu_op = mips_core_pkg::ALU_XOR;
                    op_b   = imm_zx;
                end
                mips_isa_pkg::OP_LUI: begin
                    alu_op = mips_core_pkg::ALU_LUI;
                    op_b   = imm_zx;
                    fwd_a  = 1'b0;  // rs is not read
                end
                default: ri = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
            d_wen   <= 1'b0;
            d_ri    <= 1'b0;
        end else begin
            d_valid <= q_valid;
            d_wen   <= q_valid && !ri;
            d_ri    <= q_valid && ri;
        end
    end

    always_ff @(posedge clk) begin
        d_pc     <= q_pc;
        d_alu_op <= alu_op;
        d_op_a   <= op_a;
        d_op_b   <= op_b;
        d_fwd_a  <= fwd_a;
        d_fwd_b  <= fwd_b;
        d_src_a  <= ir.r.rs;
        d_src_b  <= ir.r.rt;
        d_dest   <= dest;
    end

endmodule

//--- src/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 d_valid,
    input  logic [mips_core_pkg::WORD_W-1:0]     d_pc,
    input  logic [mips_core_pkg::ALU_OP_W-1:0]   d_alu_op,
    input  logic [mips_core_pkg::WORD_W-1:0]     d_op_a,
    input  logic [mips_core_pkg::WORD_W-1:0]     d_op_b,
    input  logic                                 d_fwd_a,
    input  logic                                 d_fwd_b,
    input  logic [mips_core_pkg::REG_ADDR_W-1:0] d_src_a,
    input  logic [mips_core_pkg::REG_ADDR_W-1:0] d_src_b,
    input  logic [mips_core_pkg::REG_ADDR_W-1:0] d_dest,
    input  logic                                 d_wen,
    input  logic                                 d_ri,
    input  logic                                 r_wen,
    input  logic [mips_core_pkg::REG_ADDR_W-1:0] r_dest,
    input  logic [mips_core_pkg::WORD_W-1:0]     r_data,
    output logic                                 e_valid,
    output logic [mips_core_pkg::WORD_W-1:0]     e_pc,
    output logic                                 e_wen,
    output logic [mips_core_pkg::REG_ADDR_W-1:0] e_dest,
    output logic [mips_core_pkg::WORD_W-1:0]     e_result,
    output logic                                 e_ri
);

    logic [mips_core_pkg::WORD_W-1:0] a, b, result;

    // the younger result in e_* wins over the older one in r_*
    function automatic logic [mips_core_pkg::WORD_W-1:0] bypass(
        input logic [mips_core_pkg::WORD_W-1:0]     op,
        input logic                                 fwd,
        input logic [mips_core_pkg::REG_ADDR_W-1:0] src
    );
        logic [mips_core_pkg::WORD_W-1:0] v;
        v = op;
        if (fwd && src != '0) begin
            if (e_wen && e_dest == src)      v = e_result;
            else if (r_wen && r_dest == src) v = r_data;
        end
        return v;
    endfunction

    assign a = bypass(d_op_a, d_fwd_a, d_src_a);
    assign b = bypass(d_op_b, d_fwd_b, d_src_b);

    always_comb begin
        case (d_alu_op)
            mips_core_pkg::ALU_ADD:  result = a + b;
            mips_core_pkg::ALU_SUB:  result = a - b;
            mips_core_pkg::ALU_AND:  result = a & b;
            mips_core_pkg::ALU_OR:   result = a | b;
            mips_core_pkg::ALU_XOR:  result = a ^ b;
            mips_core_pkg::ALU_NOR:  result = ~(a | b);
            mips_core_pkg::ALU_SLT:  result = {{(mips_core_pkg::WORD_W-1){1'b0}},
                                               $signed(a) < $signed(b)};
            mips_core_pkg::ALU_SLTU: result = {{(mips_core_pkg::WORD_W-1){1'b0}}, a < b};
            mips_core_pkg::ALU_SLL:  result = b << a[4:0];
            mips_core_pkg::ALU_SRL:  result = b >> a[4:0];
            mips_core_pkg::ALU_SRA:  result = $signed(b) >>> a[4:0];
            mips_core_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
            default:                 result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid <= 1'b0;
            e_wen   <= 1'b0;
            e_ri    <= 1'b0;
        end else begin
            e_valid <= d_valid;
            e_wen   <= d_valid && d_wen;
            e_ri    <= d_valid && d_ri;
        end
    end

    always_ff @(posedge clk) begin
        e_pc     <= d_pc;
        e_dest   <= d_dest;
        e_result <= result;
    end

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wen,
    input  logic [mips_core_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [mips_core_pkg::WORD_W-1:0]     wdata,
    input  logic [mips_core_pkg::REG_ADDR_W-1:0] raddr_a,
    input  logic [mips_core_pkg::REG_ADDR_W-1:0] raddr_b,
    output logic [mips_core_pkg::WORD_W-1:0]     rdata_a,
    output logic [mips_core_pkg::WORD_W-1:0]     rdata_b
);

    logic [mips_core_pkg::WORD_W-1:0] regs [2**mips_core_pkg::REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**mips_core_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // a read of the register being written sees the new value in the same cycle
    always_comb begin
        if (raddr_a == '0)                  rdata_a = '0;
        else if (wen && waddr == raddr_a)   rdata_a = wdata;
        else                                rdata_a = regs[raddr_a];
    end

    always_comb begin
        if (raddr_b == '0)                  rdata_b = '0;
        else if (wen && waddr == raddr_b)   rdata_b = wdata;
        else                                rdata_b = regs[raddr_b];
    end

endmodule

//--- src/retire.sv
`timescale 1ns/1ps

module retire (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 e_valid,
    input  logic [mips_core_pkg::WORD_W-1:0]     e_pc,
    input  logic                                 e_wen,
    input  logic [mips_core_pkg::REG_ADDR_W-1:0] e_dest,
    input  logic [mips_core_pkg::WORD_W-1:0]     e_result,
    input  logic                                 e_ri,
    output logic                                 rt_valid,
    output logic [mips_core_pkg::WORD_W-1:0]     rt_pc,
    output logic                                 rfw_wen,
    output logic [mips_core_pkg::REG_ADDR_W-1:0] rfw_addr,
    output logic [mips_core_pkg::WORD_W-1:0]     rfw_data,
    output logic                                 exc_valid
);

    always_ff @(posedge clk) begin
        if (rst) begin
            rt_valid  <= 1'b0;
            rfw_wen   <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            rt_valid  <= e_valid;
            rfw_wen   <= e_valid && e_wen && !e_ri && e_dest != '0;  // r0 retires as no write
            exc_valid <= e_valid && e_ri;
        end
    end

    always_ff @(posedge clk) begin
        rt_pc    <= e_pc;
        rfw_addr <= e_dest;
        rfw_data <= e_result;
    end

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 instr_valid,
    input  logic [mips_core_pkg::WORD_W-1:0]     instr,
    input  logic [mips_core_pkg::WORD_W-1:0]     instr_pc,
    output logic                                 rt_valid,
    output logic [mips_core_pkg::WORD_W-1:0]     rt_pc,
    output logic                                 rfw_wen,
    output logic [mips_core_pkg::REG_ADDR_W-1:0] rfw_addr,
    output logic [mips_core_pkg::WORD_W-1:0]     rfw_data,
    output logic                                 exc_valid
);

    logic [mips_core_pkg::REG_ADDR_W-1:0] rs_addr, rt_addr;
    logic [mips_core_pkg::WORD_W-1:0]     rs_data, rt_data;

    logic                                 d_valid, d_fwd_a, d_fwd_b, d_wen, d_ri;
    logic [mips_core_pkg::WORD_W-1:0]     d_pc, d_op_a, d_op_b;
    logic [mips_core_pkg::ALU_OP_W-1:0]   d_alu_op;
    logic [mips_core_pkg::REG_ADDR_W-1:0] d_src_a, d_src_b, d_dest;

    logic                                 e_valid, e_wen, e_ri;
    logic [mips_core_pkg::WORD_W-1:0]     e_pc, e_result;
    logic [mips_core_pkg::REG_ADDR_W-1:0] e_dest;

    decode decode_i (
        .clk, .rst,
        .instr_valid, .instr, .instr_pc,
        .rs_data, .rt_data,
        .rs_addr, .rt_addr,
        .d_valid, .d_pc, .d_alu_op, .d_op_a, .d_op_b,
        .d_fwd_a, .d_fwd_b, .d_src_a, .d_src_b,
        .d_dest, .d_wen, .d_ri
    );

    // the retire outputs double as the distance-2 bypass
    execute execute_i (
        .clk, .rst,
        .d_valid, .d_pc, .d_alu_op, .d_op_a, .d_op_b,
        .d_fwd_a, .d_fwd_b, .d_src_a, .d_src_b,
        .d_dest, .d_wen, .d_ri,
        .r_wen  (rfw_wen),
        .r_dest (rfw_addr),
        .r_data (rfw_data),
        .e_valid, .e_pc, .e_wen, .e_dest, .e_result, .e_ri
    );

    retire retire_i (
        .clk, .rst,
        .e_valid, .e_pc, .e_wen, .e_dest, .e_result, .e_ri,
        .rt_valid, .rt_pc, .rfw_wen, .rfw_addr, .rfw_data, .exc_valid
    );

    regfile regfile_i (
        .clk, .rst,
        .wen     (rfw_wen),
        .waddr   (rfw_addr),
        .wdata   (rfw_data),
        .raddr_a (rs_addr),
        .raddr_b (rt_addr),
        .rdata_a (rs_data),
        .rdata_b (rt_data)
    );

endmodule

//--- tb/datapath_assertions.sv
`timescale 1ns/1ps

module datapath_assertions (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 rt_valid,
    input logic                                 rfw_wen,
    input logic [mips_core_pkg::REG_ADDR_W-1:0] rfw_addr,
    input logic                                 exc_valid
);

    // a register write only ever happens as part of a retirement
    wen_needs_retire: assert property (@(posedge clk) disable iff (rst) rfw_wen |-> rt_valid)
        else $error("rfw_wen is high without rt_valid");

    wen_not_r0: assert property (@(posedge clk) disable iff (rst) rfw_wen |-> rfw_addr != '0)
        else $error("rfw_wen is high for register 0");

    // a reserved instruction leaves the register file alone
    exc_no_write: assert property (@(posedge clk) disable iff (rst) !(exc_valid && rfw_wen))
        else $error("exc_valid and rfw_wen are high together");

    reset_clears: assert property (@(posedge clk) rst |=> !rt_valid && !rfw_wen && !exc_valid)
        else $error("retire outputs are not low in the cycle after reset");

endmodule

//--- tb/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic        wen;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        exc;
        int          due;  // cycle count at which the record must be on the retire port
    } retire_rec_t;

    logic        clk, rst, instr_valid, rt_valid, rfw_wen, exc_valid;
    logic [31:0] instr, instr_pc, rt_pc, rfw_data;
    logic [4:0]  rfw_addr;

    logic [31:0] shadow [32];
    retire_rec_t expect_q [$];
    logic [31:0] rng = 32'hc1e3_234e;
    logic [31:0] pc = 32'h0040_0000;
    int          cycle = 0, checks = 0, errors = 0, last_checks = 0, last_errors = 0;
    int          shifts [3] = '{0, 31, 1};
    int          imms [6] = '{'h0000, 'h0001, 'h7fff, 'h8000, 'hffff, 'hfffe};
    logic [5:0]  iops [7] = '{mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI,
        mips_isa_pkg::OP_SLTIU, mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI,
        mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI};
    logic [5:0]  functs [14] = '{mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL,
        mips_isa_pkg::FN_SRA, mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV,
        mips_isa_pkg::FN_SRAV, mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUBU,
        mips_isa_pkg::FN_AND, mips_isa_pkg::FN_OR, mips_isa_pkg::FN_XOR,
        mips_isa_pkg::FN_NOR, mips_isa_pkg::FN_SLT, mips_isa_pkg::FN_SLTU};

    datapath dut_i (.*);

    bind datapath datapath_assertions assertions_i (.clk(clk), .rst(rst), .rt_valid(rt_valid),
        .rfw_wen(rfw_wen), .rfw_addr(rfw_addr), .exc_valid(exc_valid));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rtype(input logic [5:0] fn, input int rs, input int rt,
                                          input int rd, input int sh);
        return {mips_isa_pkg::OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input int rs, input int rt,
                                          input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // runs one word on the shadow registers and returns what retire must report
    function automatic retire_rec_t reference(input logic [31:0] word, input logic [31:0] at);
        mips_isa_pkg::instr_t ir;
        retire_rec_t          rec;
        logic [31:0]          a, b, sx, zx, res;
        logic [4:0]           dest;
        logic                 ri;
        ir   = word;
        a    = shadow[ir.r.rs];
        b    = shadow[ir.r.rt];
        sx   = {{16{ir.i.imm[15]}}, ir.i.imm};
        zx   = {16'h0000, ir.i.imm};
        dest = ir.i.rt;
        ri   = 1'b0;
        res  = '0;
        if (ir.r.op == mips_isa_pkg::OP_SPECIAL) begin
            dest = ir.r.rd;
            case (ir.r.funct)
                mips_isa_pkg::FN_SLL:  res = b << ir.r.shamt;
                mips_isa_pkg::FN_SRL:  res = b >> ir.r.shamt;
                mips_isa_pkg::FN_SRA:  res = $signed(b) >>> ir.r.shamt;
                mips_isa_pkg::FN_SLLV: res = b << a[4:0];
                mips_isa_pkg::FN_SRLV: res = b >> a[4:0];
                mips_isa_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
                mips_isa_pkg::FN_ADDU: res = a + b;
                mips_isa_pkg::FN_SUBU: res = a - b;
                mips_isa_pkg::FN_AND:  res = a & b;
                mips_isa_pkg::FN_OR:   res = a | b;
                mips_isa_pkg::FN_XOR:  res = a ^ b;
                mips_isa_pkg::FN_NOR:  res = ~(a | b);
                mips_isa_pkg::FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                mips_isa_pkg::FN_SLTU: res = {31'b0, a < b};
                default:               ri = 1'b1;
            endcase
        end else begin
            case (ir.i.op)
                mips_isa_pkg::OP_ADDIU: res = a + sx;
                mips_isa_pkg::OP_SLTI:  res = {31'b0, $signed(a) < $signed(sx)};
                mips_isa_pkg::OP_SLTIU: res = {31'b0, a < sx};  // sign-extended and compared unsigned
                mips_isa_pkg::OP_ANDI:  res = a & zx;
                mips_isa_pkg::OP_ORI:   res = a | zx;
                mips_isa_pkg::OP_XORI:  res = a ^ zx;
                mips_isa_pkg::OP_LUI:   res = {ir.i.imm, 16'h0000};
                default:                ri = 1'b1;
            endcase
        end
        if (!ri && dest != '0) shadow[dest] = res;
        rec.pc   = at;
        rec.wen  = !ri && dest != '0;
        rec.addr = dest;
        rec.data = res;
        rec.exc  = ri;
        rec.due  = 0;
        return rec;
    endfunction

    task automatic send(input logic [31:0] word);
        retire_rec_t rec;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        instr_pc    = pc;
        rec         = reference(word, pc);
        rec.due     = cycle + 4;  // sampled at the next edge and out three edges later
        expect_q.push_back(rec);
        pc = pc + 4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic load(input int rd, input logic [31:0] value);
        send(itype(mips_isa_pkg::OP_LUI, 0, rd, int'(value[31:16])));
        send(itype(mips_isa_pkg::OP_ORI, rd, rd, int'(value[15:0])));
    endtask

    task automatic mismatch(input string field, input logic [31:0] got, input logic [31:0] want);
        $display("** Error at %0t: %s is %h, expected %h", $time, field, got, want);
        errors++;
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        instr_valid = 1'b0;
        while (expect_q.size() != 0 && waited < 16) begin
            @(posedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("timeout: %0d instructions of test %s never retired", expect_q.size(), name);
            errors++;
            expect_q.delete();
        end
        $display("test %s finished: %0d retirements checked, %0d errors", name,
                 checks - last_checks, errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    always @(negedge clk) begin
        retire_rec_t want;
        if (!rst && rt_valid) begin
            if (expect_q.size() == 0) begin
                $display("unexpected retirement at %0t of pc %h with nothing outstanding",
                         $time, rt_pc);
                errors++;
            end else begin
                want = expect_q.pop_front();
                checks++;
                if (cycle != want.due) mismatch("retire cycle", cycle, want.due);
                if (rt_pc != want.pc) mismatch("rt_pc", rt_pc, want.pc);
                if (rfw_wen != want.wen) mismatch("rfw_wen", 32'(rfw_wen), 32'(want.wen));
                if (exc_valid != want.exc) mismatch("exc_valid", 32'(exc_valid), 32'(want.exc));
                if (want.wen && rfw_addr != want.addr)
                    mismatch("rfw_addr", 32'(rfw_addr), 32'(want.addr));
                if (want.wen && rfw_data != want.data) mismatch("rfw_data", rfw_data, want.data);
            end
        end
    end

    initial begin
        logic [31:0] word;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        foreach (shadow[k]) shadow[k] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        idle(6);  // nothing may retire here
        for (int k = 0; k < 32; k++) send(rtype(mips_isa_pkg::FN_OR, k, 0, k, 0));
        finish_test("reset");

        load(1, 32'h7fff_ffff);
        load(2, 32'h8000_0000);
        load(3, 32'hffff_ffff);
        load(4, 32'h0000_0001);
        load(5, 32'h0000_001f);
        load(6, 32'h1234_5678);
        foreach (functs[f])
            for (int s = 1; s <= 6; s++)
                for (int t = 1; t <= 6; t++)  // the first three functs shift by shamt
                    send(rtype(functs[f], s, t, 10 + (s + t) % 8,
                               f < 3 ? shifts[(s + t) % 3] : 0));
        finish_test("r-type");

        foreach (iops[o])
            foreach (imms[m])
                for (int s = 1; s <= 6; s++) send(itype(iops[o], s, 20 + m, imms[m]));
        finish_test("i-type");

        // instruction i reads the register written by i-d and the one written by i-1
        for (int d = 1; d <= 4; d++)
            for (int g = 0; g < 2; g++)
                for (int i = 0; i < 12; i++) begin
                    if (i % 2 == 0)
                        send(itype(mips_isa_pkg::OP_ADDIU, 8 + i % d, 8 + i % d, 'h7ff0 + i * 3));
                    else
                        send(rtype(mips_isa_pkg::FN_SUBU, 8 + (i - 1) % d, 8 + i % d,
                                   8 + i % d, 0));
                    if (g == 1) idle(1);
                end
        finish_test("forwarding");

        send(itype(mips_isa_pkg::OP_ADDIU, 1, 0, 5));
        send(rtype(mips_isa_pkg::FN_OR, 1, 2, 0, 0));
        send(itype(mips_isa_pkg::OP_LUI, 0, 0, 'h8000));
        send(rtype(mips_isa_pkg::FN_ADDU, 0, 0, 9, 0));
        send(32'h8c22_0004);  // lw r2 is reserved here
        send(rtype(6'b011000, 3, 4, 3, 0));
        send(32'h0800_0010);
        send(32'h0060_0008);
        send(rtype(mips_isa_pkg::FN_ADDU, 2, 3, 9, 0));
        for (int k = 1; k < 8; k++) send(rtype(mips_isa_pkg::FN_OR, k, 0, k, 0));
        finish_test("special");

        for (int n = 0; n < 2000; n++) begin
            rng = xorshift32(rng);
            if (rng[31:30] == 2'b11)
                word = xorshift32(rng ^ 32'h5a5a_5a5a);
            else if (rng[31:30] == 2'b10)
                word = {iops[int'(rng[11:9]) % 7], 2'b00, rng[2:0], 2'b00, rng[5:3], rng[29:14]};
            else
                word = {mips_isa_pkg::OP_SPECIAL, 2'b00, rng[2:0], 2'b00, rng[5:3], 2'b00,
                        rng[8:6], rng[13:9], functs[int'(rng[27:24]) % 14]};
            send(word);
            rng = xorshift32(rng);
            if (rng[1:0] == 2'b00) idle(1 + int'(rng[3:2]));
        end
        finish_test("random");

        $display("%0d retirements checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- datapath.f
src/mips_isa_pkg.sv
src/mips_core_pkg.sv
src/decode.sv
src/execute.sv
src/regfile.sv
src/retire.sv
src/datapath.sv
tb/datapath_assertions.sv
tb/datapath_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module datapath_tb -f datapath.f -Mdir obj_dir -o datapath_sim
	out="$$(./obj_dir/datapath_sim)"; echo "$$out"; echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
